// File: include/racc_config.svh
// Build-time sizing of the memory ring, pulled in with `include by the RTL and the testbench
`ifndef RACC_CONFIG_SVH
`define RACC_CONFIG_SVH

// Number of memory nodes placed on the ring between injector and drain
`define RACC_NODES 4

// Words held by each RAM bank
// The word index is taken from address bits 9:2
`define RACC_RAM_WORDS 256

// Stall cycles a bank inserts before each access completes
// A value of zero gives single-cycle accesses
`define RACC_RAM_WAIT 2

// Log2 of the address window owned by one node
// Node k answers to addresses whose bits above the window equal k+1,
// so window 0 is left free and a request there reaches the drain unclaimed
`define RACC_WINDOW_BITS 16

`endif

// File: hw/racc_pkg.sv
// Shared bus field types, packet kind codes and bank FSM states, referenced by scoped names
`default_nettype none

package racc_pkg;

  // Byte address carried in the low 32 bits of a packet
  typedef logic [31:0] racc_addr_t;

  // Data word, write data in a request and read data in a response
  typedef logic [31:0] racc_data_t;

  // Byte enables, bit i enables byte i of the data word
  typedef logic [3:0] racc_mask_t;

  // Tag stamped by the injector and copied into the matching response
  typedef logic [7:0] racc_tag_t;

  // Two-bit packet kind field
  typedef logic [1:0] racc_kind_t;

  // Request travelling from the head towards a node
  localparam racc_kind_t RACC_KIND_REQ = 2'b00;

  // Response travelling from a node towards the tail
  localparam racc_kind_t RACC_KIND_RSP = 2'b10;

  // Bank controller states
  // STALL counts wait cycles, DONE waits for chip select to drop
  typedef enum logic [1:0]
  {
    BANK_IDLE,
    BANK_STALL,
    BANK_DONE
  } bank_state_t;

endpackage

`default_nettype wire

// File: hw/racc_link_if.sv
// One registered packet slot between two ring stages, upstream uses tx and downstream uses rx
`default_nettype none
`timescale 1ns/10ps

interface racc_link_if;

  // Slot occupied; an idle slot is the only place a node can insert a response
  logic                 valid;
  // Write request, or response to a write
  logic                 write;
  // Request or response, see the kind constants in the package
  racc_pkg::racc_kind_t kind;
  // Tag that pairs a response with its request
  racc_pkg::racc_tag_t  tag;
  // Byte enables of the access
  racc_pkg::racc_mask_t mask;
  // Write data in a request, prior word in a response
  racc_pkg::racc_data_t data;
  // Byte address of the access
  racc_pkg::racc_addr_t addr;

  // Upstream stage drives every field from its output register
  modport tx
  (
    output valid, write, kind, tag, mask, data, addr
  );

  // Downstream stage samples every field into its input register
  modport rx
  (
    input valid, write, kind, tag, mask, data, addr
  );

endinterface

`default_nettype wire

// File: hw/racc_inject.sv
// Ring head that turns host request strobes into tagged request packets on the first link
`default_nettype none
`timescale 1ns/10ps

module racc_inject
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 req_strobe,
  input  logic                 req_write,
  input  racc_pkg::racc_addr_t req_addr,
  input  racc_pkg::racc_mask_t req_mask,
  input  racc_pkg::racc_data_t req_data,
  output racc_pkg::racc_tag_t  req_tag,
  racc_link_if.tx              link
);

  // Running tag, wraps naturally after 256 requests
  racc_pkg::racc_tag_t tag_cnt;

  // The host sees the tag its strobe will receive in the same cycle
  assign req_tag = tag_cnt;

  // Slot occupancy and tag counter
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      tag_cnt    <= '0;
      link.valid <= 1'b0;
    end
    else
    begin
      // Without a strobe the head slot goes idle
      link.valid <= req_strobe;
      if (req_strobe)
        tag_cnt <= tag_cnt + 1'b1;
    end

  // Packet fields only change when a new request is taken
  always_ff @(posedge CLK)
    if (req_strobe)
    begin
      link.write <= req_write;
      link.kind  <= racc_pkg::RACC_KIND_REQ;
      link.tag   <= tag_cnt;
      link.mask  <= req_mask;
      link.data  <= req_data;
      link.addr  <= req_addr;
    end

endmodule

`default_nettype wire

// File: hw/racc_ram_bank.sv
// Word RAM bank with byte-masked writes that stalls every access for a fixed number of cycles
`default_nettype none
`timescale 1ns/10ps
`include "racc_config.svh"

module racc_ram_bank
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 cs,
  input  logic                 we,
  input  racc_pkg::racc_addr_t addr,
  input  racc_pkg::racc_mask_t mask,
  input  racc_pkg::racc_data_t wr_data,
  output racc_pkg::racc_data_t rd_data,
  output logic                 wait_req
);

  localparam int IDX_W = $clog2(`RACC_RAM_WORDS);
  // Wide enough to hold the wait count, at least one bit even for zero wait
  localparam int CNT_W = $clog2(`RACC_RAM_WAIT + 2);
  localparam logic [CNT_W-1:0] WAIT_CNT = CNT_W'(`RACC_RAM_WAIT);

  racc_pkg::racc_data_t  mem [`RACC_RAM_WORDS];
  racc_pkg::bank_state_t state;
  racc_pkg::bank_state_t state_nxt;
  logic [CNT_W-1:0]      cnt;
  logic [IDX_W-1:0]      idx;
  logic                  wr_en;

  // Word index starts above the byte offset
  assign idx     = addr[IDX_W+1:2];
  assign rd_data = mem[idx];

  // The first cycle of cs is stall number one, STALL counts the rest
  always_comb
  begin
    wait_req  = 1'b0;
    state_nxt = state;
    case (state)
      racc_pkg::BANK_IDLE:
      begin
        wait_req = cs && (WAIT_CNT != '0);
        if (cs)
          state_nxt = (WAIT_CNT != '0) ? racc_pkg::BANK_STALL : racc_pkg::BANK_DONE;
      end
      racc_pkg::BANK_STALL:
      begin
        wait_req = (cnt != WAIT_CNT);
        if (cnt == WAIT_CNT)
          state_nxt = racc_pkg::BANK_DONE;
      end
      racc_pkg::BANK_DONE:
        if (!cs)
          state_nxt = racc_pkg::BANK_IDLE;
      default:
        state_nxt = racc_pkg::BANK_IDLE;
    endcase
  end

  // Write lands at the edge closing the completion cycle, never in DONE
  assign wr_en = cs && we && !wait_req && (state != racc_pkg::BANK_DONE);

  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      state <= racc_pkg::BANK_IDLE;
      cnt   <= '0;
    end
    else
    begin
      state <= state_nxt;
      cnt   <= (state_nxt == racc_pkg::BANK_STALL) ? cnt + 1'b1 : '0;
    end

  // Contents start out as zero after reset
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      for (int i = 0; i < `RACC_RAM_WORDS; i++)
        mem[i] <= '0;
    end
    else if (wr_en)
    begin
      for (int b = 0; b < $bits(racc_pkg::racc_mask_t); b++)
        if (mask[b])
          mem[idx][8*b +: 8] <= wr_data[8*b +: 8];
    end

endmodule

`default_nettype wire

// File: hw/racc_ram_node.sv
// Ring node that claims requests in its address window and reinserts the responses of its bank
`default_nettype none
`timescale 1ns/10ps
`include "racc_config.svh"

module racc_ram_node
#(
  parameter racc_pkg::racc_addr_t ADDR_BASE = 32'h0001_0000
)
(
  input  logic                 CLK,
  input  logic                 RST,
  racc_link_if.rx              up,
  racc_link_if.tx              down,
  output logic                 cs,
  input  logic                 wait_req,
  output logic                 we,
  output racc_pkg::racc_addr_t addr,
  output racc_pkg::racc_mask_t mask,
  output racc_pkg::racc_data_t wr_data,
  input  racc_pkg::racc_data_t rd_data
);

  // Address bits above the window select the node
  localparam racc_pkg::racc_addr_t WIN_MASK =
    {$bits(racc_pkg::racc_addr_t){1'b1}} << `RACC_WINDOW_BITS;

  // Input register holding a copy of the upstream slot
  logic                 din_valid;
  logic                 din_write;
  racc_pkg::racc_kind_t din_kind;
  racc_pkg::racc_tag_t  din_tag;
  racc_pkg::racc_mask_t din_mask;
  racc_pkg::racc_data_t din_data;
  racc_pkg::racc_addr_t din_addr;

  // Held request that stays on the RAM port until the access completes
  logic                 req_valid;
  logic                 req_write;
  racc_pkg::racc_tag_t  req_tag;
  racc_pkg::racc_mask_t req_mask;
  racc_pkg::racc_data_t req_data;
  racc_pkg::racc_addr_t req_addr;

  // Held response that waits for an idle slot on the input side
  logic                 rsp_valid;
  logic                 rsp_write;
  racc_pkg::racc_tag_t  rsp_tag;
  racc_pkg::racc_mask_t rsp_mask;
  racc_pkg::racc_data_t rsp_data;
  racc_pkg::racc_addr_t rsp_addr;

  logic claim;
  logic done;

  // Only one access is in flight per node, so a busy node lets requests pass
  assign claim = din_valid && (din_kind == racc_pkg::RACC_KIND_REQ) &&
                 ((din_addr & WIN_MASK) == (ADDR_BASE & WIN_MASK)) &&
                 !req_valid && !rsp_valid;

  // The bank finishes in the cycle where the port is selected and not stalled
  assign done = req_valid && !wait_req;

  // The RAM port is a direct view of the held request
  assign cs      = req_valid;
  assign we      = req_write;
  assign addr    = req_addr;
  assign mask    = req_mask;
  assign wr_data = req_data;

  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      din_valid  <= 1'b0;
      req_valid  <= 1'b0;
      rsp_valid  <= 1'b0;
      down.valid <= 1'b0;
    end
    else
    begin
      din_valid <= up.valid;
      if (claim)
        req_valid <= 1'b1;
      else if (done)
        req_valid <= 1'b0;
      // A pending response leaves as soon as the input slot is idle
      if (done)
        rsp_valid <= 1'b1;
      else if (!din_valid)
        rsp_valid <= 1'b0;
      // A claimed request becomes an idle slot downstream
      down.valid <= !claim && (din_valid || rsp_valid);
    end

  always_ff @(posedge CLK)
  begin
    din_write <= up.write;
    din_kind  <= up.kind;
    din_tag   <= up.tag;
    din_mask  <= up.mask;
    din_data  <= up.data;
    din_addr  <= up.addr;
    if (claim)
    begin
      req_write <= din_write;
      req_tag   <= din_tag;
      req_mask  <= din_mask;
      req_data  <= din_data;
      req_addr  <= din_addr;
    end
    // The response carries the word as it stood before any write
    if (done)
    begin
      rsp_write <= req_write;
      rsp_tag   <= req_tag;
      rsp_mask  <= req_mask;
      rsp_data  <= rd_data;
      rsp_addr  <= req_addr;
    end
    // Traffic in the input slot has priority over the held response
    if (din_valid)
    begin
      down.write <= din_write;
      down.kind  <= din_kind;
      down.tag   <= din_tag;
      down.mask  <= din_mask;
      down.data  <= din_data;
      down.addr  <= din_addr;
    end
    else
    begin
      down.write <= rsp_write;
      down.kind  <= racc_pkg::RACC_KIND_RSP;
      down.tag   <= rsp_tag;
      down.mask  <= rsp_mask;
      down.data  <= rsp_data;
      down.addr  <= rsp_addr;
    end
  end

endmodule

`default_nettype wire

// File: hw/racc_drain.sv
// Ring tail that turns arriving packets into host response strobes and flags unclaimed requests
`default_nettype none
`timescale 1ns/10ps

module racc_drain
(
  input  logic                 CLK,
  input  logic                 RST,
  racc_link_if.rx              link,
  output logic                 rsp_strobe,
  output logic                 rsp_error,
  output logic                 rsp_write,
  output racc_pkg::racc_tag_t  rsp_tag,
  output racc_pkg::racc_data_t rsp_data
);

  logic is_rsp;

  // Anything still marked as a request at the tail was accepted by no node
  assign is_rsp = (link.kind == racc_pkg::RACC_KIND_RSP);

  // Every valid slot ends here and produces exactly one strobe
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      rsp_strobe <= 1'b0;
      rsp_error  <= 1'b0;
    end
    else
    begin
      rsp_strobe <= link.valid;
      rsp_error  <= link.valid && !is_rsp;
    end

  // Result fields hold their last value between strobes
  always_ff @(posedge CLK)
    if (link.valid)
    begin
      rsp_write <= link.write;
      rsp_tag   <= link.tag;
      // Write data of a lost request is not returned to the host
      rsp_data  <= is_rsp ? link.data : '0;
    end

endmodule

`default_nettype wire

// File: hw/racc_ram_ring.sv
// Top level of the memory ring, chaining injector, node and bank pairs and drain with plain host ports
`default_nettype none
`timescale 1ns/10ps
`include "racc_config.svh"

module racc_ram_ring
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 req_strobe,
  input  logic                 req_write,
  input  racc_pkg::racc_addr_t req_addr,
  input  racc_pkg::racc_mask_t req_mask,
  input  racc_pkg::racc_data_t req_data,
  output racc_pkg::racc_tag_t  req_tag,
  output logic                 rsp_strobe,
  output logic                 rsp_error,
  output logic                 rsp_write,
  output racc_pkg::racc_tag_t  rsp_tag,
  output racc_pkg::racc_data_t rsp_data
);

  // Link k feeds node k, the last link feeds the drain
  racc_link_if link [0:`RACC_NODES] ();

  racc_inject inject_i
  (
    .CLK        (CLK),
    .RST        (RST),
    .req_strobe (req_strobe),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_mask   (req_mask),
    .req_data   (req_data),
    .req_tag    (req_tag),
    .link       (link[0])
  );

  for (genvar k = 0; k < `RACC_NODES; k++)
  begin : g_node
    logic                 cs;
    logic                 we;
    logic                 wait_req;
    racc_pkg::racc_addr_t addr;
    racc_pkg::racc_mask_t mask;
    racc_pkg::racc_data_t wr_data;
    racc_pkg::racc_data_t rd_data;

    // Window 0 belongs to no node
    racc_ram_node #(
      .ADDR_BASE (racc_pkg::racc_addr_t'((k + 1) << `RACC_WINDOW_BITS))
    ) node_i (
      .CLK (CLK), .RST (RST), .up (link[k]), .down (link[k+1]),
      .cs (cs), .wait_req (wait_req), .we (we), .addr (addr),
      .mask (mask), .wr_data (wr_data), .rd_data (rd_data)
    );

    racc_ram_bank bank_i
    (
      .CLK (CLK), .RST (RST), .cs (cs), .we (we), .addr (addr),
      .mask (mask), .wr_data (wr_data), .rd_data (rd_data), .wait_req (wait_req)
    );
  end

  racc_drain drain_i
  (
    .CLK (CLK), .RST (RST), .link (link[`RACC_NODES]),
    .rsp_strobe (rsp_strobe), .rsp_error (rsp_error), .rsp_write (rsp_write),
    .rsp_tag (rsp_tag), .rsp_data (rsp_data)
  );

endmodule

`default_nettype wire

// File: sim/racc_ram_ring_chk.sv
// Concurrent checks on the RAM port and output slot of a ring node, bound into every node instance
`default_nettype none
`timescale 1ns/10ps

module racc_ram_ring_chk
(
  input wire logic                 CLK,
  input wire logic                 RST,
  input wire logic                 cs,
  input wire logic                 wait_req,
  input wire logic                 we,
  input wire racc_pkg::racc_addr_t addr,
  input wire racc_pkg::racc_mask_t mask,
  input wire racc_pkg::racc_data_t wr_data,
  input wire logic                 down_valid,
  input wire racc_pkg::racc_kind_t down_kind
);

  // A node holding reset keeps its bank deselected
  cs_in_reset_a: assert property (@(posedge CLK) (RST && $past(RST)) |-> !cs)
    else $error("cs high while the node is held in reset");

  // The held request must not move while the bank stalls it
  port_stable_a: assert property (@(posedge CLK) disable iff (RST)
    $past(cs && wait_req) |-> ($stable(addr) && $stable(we) && $stable(mask) &&
                               $stable(wr_data)))
    else $error("RAM port changed during a wait cycle");

  // An occupied slot always carries a defined packet kind
  kind_known_a: assert property (@(posedge CLK) disable iff (RST)
    down_valid |-> !$isunknown(down_kind))
    else $error("valid output slot with unknown kind");

endmodule

// Every node gets its own copy of the checks
bind racc_ram_node racc_ram_ring_chk chk_i
(
  .CLK (CLK), .RST (RST), .cs (cs), .wait_req (wait_req), .we (we), .addr (addr),
  .mask (mask), .wr_data (wr_data), .down_valid (down.valid), .down_kind (down.kind)
);

`default_nettype wire

// File: sim/racc_ram_ring_tb.sv
// Self-checking testbench for the memory ring, issues host requests and checks each response by tag
`default_nettype none
`timescale 1ns/10ps
`include "racc_config.svh"

module racc_ram_ring_tb;

  // Cycles any single wait may take before it is declared stuck
  localparam int TIMEOUT = 300;

  logic                 CLK;
  logic                 RST;
  logic                 req_strobe;
  logic                 req_write;
  racc_pkg::racc_addr_t req_addr;
  racc_pkg::racc_mask_t req_mask;
  racc_pkg::racc_data_t req_data;
  racc_pkg::racc_tag_t  req_tag;
  logic                 rsp_strobe;
  logic                 rsp_error;
  logic                 rsp_write;
  racc_pkg::racc_tag_t  rsp_tag;
  racc_pkg::racc_data_t rsp_data;

  // Shadow copy of every bank, updated in issue order
  racc_pkg::racc_data_t shadow [`RACC_NODES][`RACC_RAM_WORDS];
  // Expected results, one entry per tag value
  logic                 pending [256];
  logic                 exp_error [256];
  logic                 exp_write [256];
  racc_pkg::racc_data_t exp_data [256];
  int                   exp_node [256];
  // A node with a request in flight must not get another one
  logic                 busy [`RACC_NODES];
  racc_pkg::racc_tag_t  next_tag;
  logic [31:0]          seed;
  int                   outstanding;
  int                   mismatches;
  int                   failures;

  racc_ram_ring dut_i
  (
    .CLK (CLK), .RST (RST), .req_strobe (req_strobe), .req_write (req_write),
    .req_addr (req_addr), .req_mask (req_mask), .req_data (req_data), .req_tag (req_tag),
    .rsp_strobe (rsp_strobe), .rsp_error (rsp_error), .rsp_write (rsp_write),
    .rsp_tag (rsp_tag), .rsp_data (rsp_data)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Linear congruential generator for addresses, data, masks and gaps
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Node that owns an address, or -1 when the address is outside every window
  function automatic int node_of(input racc_pkg::racc_addr_t a);
    int n;
    n = int'(a >> `RACC_WINDOW_BITS) - 1;
    if (n < 0 || n >= `RACC_NODES)
      return -1;
    return n;
  endfunction

  // Word aligned address of a word index inside the window of node k
  function automatic racc_pkg::racc_addr_t node_addr(input int k, input logic [7:0] idx);
    return racc_pkg::racc_addr_t'((k + 1) << `RACC_WINDOW_BITS) | {22'h0, idx, 2'b00};
  endfunction

  // Expected response word, which is the word before the access; writes merge enabled bytes
  function automatic racc_pkg::racc_data_t ref_access(input logic write,
    input racc_pkg::racc_addr_t a, input racc_pkg::racc_mask_t m, input racc_pkg::racc_data_t d);
    int n;
    racc_pkg::racc_data_t old;
    n = node_of(a);
    if (n < 0)
      return '0;
    old = shadow[n][a[9:2]];
    if (write)
      for (int b = 0; b < 4; b++)
        if (m[b])
          shadow[n][a[9:2]][8*b +: 8] = d[8*b +: 8];
    return old;
  endfunction

  task automatic compare_data(input string name, input racc_pkg::racc_data_t got,
    input racc_pkg::racc_data_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic compare_tag(input string name, input racc_pkg::racc_tag_t got,
    input racc_pkg::racc_tag_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %02h expected %02h", name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH %s got %01h expected %01h", name, got, exp);
    end
  endtask

  // Idle cycles on the host side, leaving slots free for responses
  task automatic idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge CLK);
      #1;
    end
  endtask

  // Presents one strobe and records what its response must look like
  task automatic issue(input logic write, input racc_pkg::racc_addr_t a,
    input racc_pkg::racc_mask_t m, input racc_pkg::racc_data_t d);
    int n;
    n = node_of(a);
    req_strobe = 1'b1;
    req_write  = write;
    req_addr   = a;
    req_mask   = m;
    req_data   = d;
    // Tags count up from zero in strobe order
    compare_tag("req_tag", req_tag, next_tag);
    pending[next_tag]   = 1'b1;
    exp_error[next_tag] = (n < 0);
    exp_write[next_tag] = write;
    exp_data[next_tag]  = ref_access(write, a, m, d);
    exp_node[next_tag]  = n;
    if (n >= 0)
      busy[n] = 1'b1;
    outstanding++;
    next_tag = next_tag + 8'd1;
    @(posedge CLK);
    #1;
    req_strobe = 1'b0;
  endtask

  task automatic wait_node_free(input int k);
    int t;
    t = 0;
    while (busy[k] && t < TIMEOUT)
    begin
      @(posedge CLK);
      #1;
      t++;
    end
    if (busy[k])
    begin
      failures++;
      $display("Timeout waiting for node %0d to return its response", k);
      busy[k] = 1'b0;
    end
  endtask

  task automatic wait_all_done();
    int t;
    t = 0;
    while (outstanding > 0 && t < TIMEOUT)
    begin
      @(posedge CLK);
      #1;
      t++;
    end
    if (outstanding > 0)
    begin
      failures++;
      $display("Timeout with %0d requests still waiting for a response", outstanding);
      // Forget the lost requests so that later phases still run
      outstanding = 0;
      for (int i = 0; i < 256; i++)
        pending[i] = 1'b0;
      for (int i = 0; i < `RACC_NODES; i++)
        busy[i] = 1'b0;
    end
  endtask

  // Responses are sampled on the falling edge, half a cycle after the drain registers them
  always @(negedge CLK)
    if (!RST && rsp_strobe)
    begin
      if (!pending[rsp_tag])
      begin
        failures++;
        $display("Response with tag %02h arrived while no request with that tag was open",
                 rsp_tag);
      end
      else
      begin
        compare_flag("rsp_error", rsp_error, exp_error[rsp_tag]);
        compare_flag("rsp_write", rsp_write, exp_write[rsp_tag]);
        compare_data("rsp_data", rsp_data, exp_data[rsp_tag]);
        pending[rsp_tag] = 1'b0;
        outstanding--;
        if (exp_node[rsp_tag] >= 0)
          busy[exp_node[rsp_tag]] = 1'b0;
      end
    end

  initial
  begin
    logic [31:0]          r;
    racc_pkg::racc_addr_t a;
    int                   k;
    RST         = 1'b1;
    req_strobe  = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_mask    = '0;
    req_data    = '0;
    seed        = 32'hc487_70e7;
    next_tag    = '0;
    outstanding = 0;
    mismatches  = 0;
    failures    = 0;
    for (int n = 0; n < `RACC_NODES; n++)
    begin
      busy[n] = 1'b0;
      for (int w = 0; w < `RACC_RAM_WORDS; w++)
        shadow[n][w] = '0;
    end
    for (int i = 0; i < 256; i++)
      pending[i] = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;
    idle(2);

    // Fresh banks read back as zero
    for (k = 0; k < `RACC_NODES; k++)
    begin
      r = lcg_next();
      issue(1'b0, node_addr(k, r[9:2]), 4'hf, '0);
      idle(1);
    end
    wait_all_done();

    // Two masked writes to one word, each read back, so bytes of both get merged
    for (k = 0; k < `RACC_NODES; k++)
    begin
      r = lcg_next();
      a = node_addr(k, r[9:2]);
      issue(1'b1, a, r[13:10], lcg_next());
      wait_all_done();
      issue(1'b0, a, 4'hf, '0);
      wait_all_done();
      issue(1'b1, a, r[17:14], lcg_next());
      wait_all_done();
      issue(1'b0, a, 4'hf, '0);
      wait_all_done();
    end

    // Random traffic over all nodes, enough requests to wrap the tag counter
    for (int n = 0; n < 240; n++)
    begin
      r = lcg_next();
      k = int'(r[23:16]) % `RACC_NODES;
      wait_node_free(k);
      issue(r[31], node_addr(k, {4'h0, r[5:2]}), r[13:10], lcg_next());
      idle(int'(r[25:24]) + 1);
    end
    wait_all_done();

    // Window 0 and the window past the last node belong to nobody
    issue(1'b0, 32'h0000_0040, 4'hf, '0);
    idle(1);
    issue(1'b1, racc_pkg::racc_addr_t'((`RACC_NODES + 1) << `RACC_WINDOW_BITS) | 32'h10,
          4'h3, lcg_next());
    idle(1);
    wait_all_done();

    // Back-to-back strobes, one per node, then a gap for the responses
    for (k = 0; k < `RACC_NODES; k++)
    begin
      r = lcg_next();
      issue(1'b1, node_addr(k, r[9:2]), r[13:10], lcg_next());
    end
    idle(4);
    wait_all_done();
    idle(10);

    $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hw/racc_pkg.sv
hw/racc_link_if.sv
hw/racc_inject.sv
hw/racc_ram_bank.sv
hw/racc_ram_node.sv
hw/racc_drain.sv
hw/racc_ram_ring.sv
sim/racc_ram_ring_chk.sv
sim/racc_ram_ring_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the memory ring testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal -j 0 \
  --top-module racc_ram_ring_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vracc_ram_ring_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
